// File: Makefile
SRCS := $(wildcard src/*.sv verif/*.sv)

.PHONY: run clean

obj_dir/VtbControlUnit: compile.f $(SRCS)
	verilator --binary --top-module tbControlUnit -f compile.f -o VtbControlUnit

run: obj_dir/VtbControlUnit
	./obj_dir/VtbControlUnit | tee /dev/stderr | grep -q "All tests passed!"

clean:
	rm -rf obj_dir

// File: compile.f
src/cuPkg.sv
src/opDecoder.sv
src/stateSequencer.sv
src/controlWordGen.sv
src/controlUnit.sv
verif/cuChecker.sv
verif/tbControlUnit.sv

// File: src/controlUnit.sv
module controlUnit
   import cuPkg::*;
(
   input  logic       CLK,
   input  logic       Reset,
   input  opcode_t    Opcode,
   output state_t     State,
   output ctrlWord_t  Ctrl
);

   instrClass_t cls;
   aluOp_t      aluSel;

   opDecoder decoder (
      .Opcode (Opcode),
      .Cls    (cls),
      .AluSel (aluSel)
   );

   stateSequencer sequencer (
      .CLK   (CLK),
      .Reset (Reset),
      .Cls   (cls),
      .State (State)
   );

   controlWordGen wordGen (
      .State  (State),
      .AluSel (aluSel),
      .Ctrl   (Ctrl)
   );

endmodule

// File: src/controlWordGen.sv
module controlWordGen
   import cuPkg::*;
(
   input  state_t     State,
   input  aluOp_t     AluSel,
   output ctrlWord_t  Ctrl
);

   always_comb
   begin
      Ctrl = CtrlIdle;
      case (State)
         Fetch:
         begin
            Ctrl.aluOp     = aluAdd;      // PC + 4
            Ctrl.pcWrite   = 1'b1;
            Ctrl.iRegWrite = 1'b1;
            Ctrl.aluSrcB   = 2'd1;
            Ctrl.pcData    = pcFromAlu;
         end
         Decode:
         begin
            Ctrl.aluOp   = aluAdd;        // Branch target precompute
            Ctrl.signExt = 1'b1;
            Ctrl.aluSrcB = 2'd2;
         end
         RegAlu:
         begin
            Ctrl.aluOp   = AluSel;
            Ctrl.aluSrcA = 1'b1;
         end
         ImmAlu:
         begin
            Ctrl.aluOp   = AluSel;
            Ctrl.aluSrcA = 1'b1;
            Ctrl.aluSrcB = 2'd2;
         end
         MemAddr:
         begin
            Ctrl.aluOp   = aluAdd;        // Base plus offset
            Ctrl.signExt = 1'b1;
            Ctrl.aluSrcA = 1'b1;
            Ctrl.aluSrcB = 2'd2;
         end
         Beq:
         begin
            Ctrl.aluOp      = aluSub;
            Ctrl.aluSrcA    = 1'b1;
            Ctrl.pcData     = pcFromBranch;
            Ctrl.pcWriteBeq = 1'b1;
         end
         Bne:
         begin
            Ctrl.aluOp      = aluSub;
            Ctrl.aluSrcA    = 1'b1;
            Ctrl.pcData     = pcFromBranch;
            Ctrl.pcWriteBne = 1'b1;
         end
         Jump:
         begin
            Ctrl.aluOp   = aluOr;
            Ctrl.pcWrite = 1'b1;
            Ctrl.pcData  = pcFromJump;
         end
         JumpReg:
         begin
            Ctrl.pcWrite = 1'b1;
            Ctrl.pcData  = pcFromReg;
         end
         JalLink:
         begin
            // Link address into the ALU output register
            Ctrl.aluOp   = aluAdd;
            Ctrl.aluSrcB = 2'd3;
         end
         Lui:        Ctrl.gRegWrite = 1'b1;
         RegWrite:
         begin
            Ctrl.writeAddr = 2'd2;        // rd
            Ctrl.writeData = 2'd2;
            Ctrl.gRegWrite = 1'b1;
         end
         ImmWrite:
         begin
            Ctrl.writeData = 2'd2;
            Ctrl.gRegWrite = 1'b1;
         end
         LoadRead:   Ctrl.iorD = 2'd1;
         StoreWrite:
         begin
            Ctrl.iorD         = 2'd1;
            Ctrl.memWrite     = 1'b1;
            Ctrl.memWriteData = 2'd1;
         end
         JalJump:
         begin
            Ctrl.pcWrite   = 1'b1;
            Ctrl.writeAddr = 2'd3;        // Link register
            Ctrl.writeData = 2'd2;
            Ctrl.gRegWrite = 1'b1;
            Ctrl.pcData    = pcFromJump;
         end
         LoadWrite:
         begin
            Ctrl.writeAddr = 2'd1;
            Ctrl.writeData = 2'd1;        // Memory data register
            Ctrl.gRegWrite = 1'b1;
         end
         Blank:      Ctrl = CtrlIdle;
         default:    Ctrl = CtrlIdle;
      endcase
   end

endmodule

// File: src/cuPkg.sv
package cuPkg;

   // Control word field widths
   localparam int AluOpW  = 3;
   localparam int SrcBW   = 2;
   localparam int PcDataW = 3;
   localparam int SelW    = 2;

   // Instruction register opcode, value 5 is illegal
   typedef enum logic [3:0] {
      opAdd  = 4'd0,
      opSub  = 4'd1,
      opAnd  = 4'd2,
      opOr   = 4'd3,
      opAddi = 4'd4,
      opOri  = 4'd6,
      opSlt  = 4'd7,
      opLw   = 4'd8,
      opSw   = 4'd9,
      opLui  = 4'd10,
      opBeq  = 4'd11,
      opBne  = 4'd12,
      opJal  = 4'd13,
      opJ    = 4'd14,
      opJr   = 4'd15
   } opcode_t;

   typedef enum logic [4:0] {
      Fetch,
      Decode,
      RegAlu, ImmAlu, MemAddr, Beq, Bne, Jump, JumpReg, JalLink, Lui,  // Third cycle
      RegWrite, ImmWrite, LoadRead, StoreWrite, JalJump,              // Fourth cycle
      LoadWrite, Blank                                                // Fifth cycle
   } state_t;

   typedef enum logic [AluOpW-1:0] {
      aluAnd = 3'd0,
      aluOr  = 3'd1,
      aluAdd = 3'd2,
      aluSub = 3'd6,
      aluSlt = 3'd7
   } aluOp_t;

   typedef enum logic [3:0] {
      clsRegAlu, clsImmAlu, clsLoad, clsStore, clsLui, clsBeq, clsBne,
      clsJal, clsJump, clsJumpReg, clsIllegal
   } instrClass_t;

   // PC mux select
   typedef enum logic [PcDataW-1:0] {
      pcFromReg    = 3'd0,
      pcFromAlu    = 3'd1,
      pcFromBranch = 3'd2,
      pcFromJump   = 3'd5
   } pcSrc_t;

   typedef struct packed {
      aluOp_t              aluOp;
      logic                pcWriteBeq;
      logic                pcWriteBne;
      logic                pcWrite;
      logic [SelW-1:0]     iorD;          // Memory address select
      logic                iRegWrite;
      logic [SelW-1:0]     writeAddr;     // Register file write address select
      logic [SelW-1:0]     writeData;     // Register file write data select
      logic                signExt;
      logic                gRegWrite;
      logic                aluSrcA;
      logic [SrcBW-1:0]    aluSrcB;
      pcSrc_t              pcData;
      logic                memWrite;
      logic [SelW-1:0]     memWriteData;
   } ctrlWord_t;

   localparam ctrlWord_t CtrlIdle = '0;

endpackage

// File: src/opDecoder.sv
module opDecoder
   import cuPkg::*;
(
   input  opcode_t      Opcode,
   output instrClass_t  Cls,
   output aluOp_t       AluSel
);

   always_comb
   begin
      Cls    = clsIllegal;
      AluSel = aluAnd;    // Don't care for non-ALU classes
      case (Opcode)
         opAdd:
         begin
            Cls    = clsRegAlu;
            AluSel = aluAdd;
         end
         opSub:
         begin
            Cls    = clsRegAlu;
            AluSel = aluSub;
         end
         opAnd:   Cls = clsRegAlu;
         opOr:
         begin
            Cls    = clsRegAlu;
            AluSel = aluOr;
         end
         opSlt:
         begin
            Cls    = clsRegAlu;
            AluSel = aluSlt;
         end
         opAddi:
         begin
            Cls    = clsImmAlu;
            AluSel = aluAdd;
         end
         opOri:
         begin
            Cls    = clsImmAlu;
            AluSel = aluOr;
         end
         opLw:
         begin
            Cls    = clsLoad;
            AluSel = aluAdd;
         end
         opSw:
         begin
            Cls    = clsStore;
            AluSel = aluAdd;
         end
         opLui:   Cls = clsLui;
         opBeq:   Cls = clsBeq;
         opBne:   Cls = clsBne;
         opJal:   Cls = clsJal;
         opJ:     Cls = clsJump;
         opJr:    Cls = clsJumpReg;
         default: Cls = clsIllegal;
      endcase
   end

endmodule

// File: src/stateSequencer.sv
module stateSequencer
   import cuPkg::*;
(
   input  logic         CLK,
   input  logic         Reset,
   input  instrClass_t  Cls,
   output state_t       State
);

   state_t nextState;

   always_ff @(posedge CLK or posedge Reset)
   begin
      if (Reset)
         State <= Fetch;
      else
         State <= nextState;
   end

   always_comb
   begin
      nextState = Fetch;
      case (State)
         Fetch:
            nextState = Decode;
         Decode:
         begin
            case (Cls)
               clsRegAlu:  nextState = RegAlu;
               clsImmAlu:  nextState = ImmAlu;
               clsLoad,
               clsStore:   nextState = MemAddr;
               clsLui:     nextState = Lui;
               clsBeq:     nextState = Beq;
               clsBne:     nextState = Bne;
               clsJal:     nextState = JalLink;
               clsJump:    nextState = Jump;
               clsJumpReg: nextState = JumpReg;
               default:    nextState = Fetch;    // Illegal opcode
            endcase
         end
         MemAddr:
         begin
            // Only load and store reach this state
            if (Cls == clsStore)
               nextState = StoreWrite;
            else
               nextState = LoadRead;
         end
         RegAlu:     nextState = RegWrite;
         ImmAlu:     nextState = ImmWrite;
         LoadRead:   nextState = LoadWrite;
         StoreWrite: nextState = Blank;
         JalLink:    nextState = JalJump;
         // Last state of each instruction
         Beq,
         Bne,
         Jump,
         JumpReg,
         Lui,
         RegWrite,
         ImmWrite,
         JalJump,
         LoadWrite,
         Blank:      nextState = Fetch;
         default:    nextState = Fetch;
      endcase
   end

endmodule

// File: verif/cuChecker.sv
module cuChecker
   import cuPkg::*;
(
   input  logic       CLK,
   input  logic       Reset,
   input  opcode_t    Opcode,
   input  state_t     State,
   input  ctrlWord_t  Ctrl,
   output int         ErrCount
);

   timeunit 1ns;
   timeprecision 100ps;

   int        errors = 0;
   state_t    predState = Fetch;   // State expected after the next rising edge
   state_t    expState;
   ctrlWord_t expWord;

   assign ErrCount = errors;

   function automatic aluOp_t expAluOp(opcode_t op);
      aluOp_t a;
      case (op)
         opAdd, opAddi, opLw, opSw: a = aluAdd;
         opSub:                     a = aluSub;
         opOr, opOri:               a = aluOr;
         opSlt:                     a = aluSlt;
         default:                   a = aluAnd;
      endcase
      return a;
   endfunction

   function automatic state_t expNextState(state_t s, opcode_t op);
      state_t n;
      n = Fetch;
      case (s)
         Fetch: n = Decode;
         Decode:
         begin
            case (op)
               opAdd, opSub, opAnd, opOr, opSlt: n = RegAlu;
               opAddi, opOri:                    n = ImmAlu;
               opLw, opSw:                       n = MemAddr;
               opLui:                            n = Lui;
               opBeq:                            n = Beq;
               opBne:                            n = Bne;
               opJal:                            n = JalLink;
               opJ:                              n = Jump;
               opJr:                             n = JumpReg;
               default:                          n = Fetch;
            endcase
         end
         MemAddr:    n = (op == opSw) ? StoreWrite : LoadRead;
         RegAlu:     n = RegWrite;
         ImmAlu:     n = ImmWrite;
         LoadRead:   n = LoadWrite;
         StoreWrite: n = Blank;
         JalLink:    n = JalJump;
         default:    n = Fetch;
      endcase
      return n;
   endfunction

   function automatic ctrlWord_t expCtrl(state_t s, opcode_t op);
      ctrlWord_t c;
      c = '0;
      case (s)
         Fetch:
         begin
            c.aluOp = aluAdd;
            c.pcWrite = 1'b1;
            c.iRegWrite = 1'b1;
            c.aluSrcB = 2'd1;
            c.pcData = pcFromAlu;
         end
         Decode:
         begin
            c.aluOp = aluAdd;
            c.signExt = 1'b1;
            c.aluSrcB = 2'd2;
         end
         RegAlu:
         begin
            c.aluOp = expAluOp(op);
            c.aluSrcA = 1'b1;
         end
         ImmAlu:
         begin
            c.aluOp = expAluOp(op);
            c.aluSrcA = 1'b1;
            c.aluSrcB = 2'd2;
         end
         MemAddr:
         begin
            c.aluOp = aluAdd;
            c.signExt = 1'b1;
            c.aluSrcA = 1'b1;
            c.aluSrcB = 2'd2;
         end
         Beq, Bne:
         begin
            c.aluOp = aluSub;
            c.aluSrcA = 1'b1;
            c.pcData = pcFromBranch;
            c.pcWriteBeq = (s == Beq);
            c.pcWriteBne = (s == Bne);
         end
         Jump:
         begin
            c.aluOp = aluOr;
            c.pcWrite = 1'b1;
            c.pcData = pcFromJump;
         end
         JumpReg:
         begin
            c.pcWrite = 1'b1;
            c.pcData = pcFromReg;
         end
         JalLink:
         begin
            c.aluOp = aluAdd;
            c.aluSrcB = 2'd3;
         end
         Lui: c.gRegWrite = 1'b1;
         RegWrite:
         begin
            c.writeAddr = 2'd2;
            c.writeData = 2'd2;
            c.gRegWrite = 1'b1;
         end
         ImmWrite:
         begin
            c.writeData = 2'd2;
            c.gRegWrite = 1'b1;
         end
         LoadRead: c.iorD = 2'd1;
         StoreWrite:
         begin
            c.iorD = 2'd1;
            c.memWrite = 1'b1;
            c.memWriteData = 2'd1;
         end
         JalJump:
         begin
            c.pcWrite = 1'b1;
            c.writeAddr = 2'd3;
            c.writeData = 2'd2;
            c.gRegWrite = 1'b1;
            c.pcData = pcFromJump;
         end
         LoadWrite:
         begin
            c.writeAddr = 2'd1;
            c.writeData = 2'd1;
            c.gRegWrite = 1'b1;
         end
         default: c = '0;     // Blank
      endcase
      return c;
   endfunction

   // Outputs settle between edges, so compare on the falling edge
   always @(negedge CLK)
   begin
      if (Reset)
         expState = Fetch;
      else
         expState = predState;
      expWord = expCtrl(expState, Opcode);
      if (State !== expState)
      begin
         errors++;
         $display("Fail time=%0t State expected %s got %s", $time, expState.name(),
                  State.name());
      end
      if (Ctrl !== expWord)
      begin
         errors++;
         $display("Fail time=%0t Ctrl expected %h got %h", $time, expWord, Ctrl);
      end
      // Reset still seen high at the next rising edge
      if (Reset)
         predState = Fetch;
      else
         predState = expNextState(expState, Opcode);
   end

endmodule

// File: verif/tbControlUnit.sv
module tbControlUnit
   import cuPkg::*;
();

   timeunit 1ns;
   timeprecision 100ps;

   logic      CLK = 1'b0;
   logic      Reset;
   opcode_t   Opcode;
   state_t    State;
   ctrlWord_t Ctrl;
   int        checkErrors;
   int        lengthErrors;
   int        timeouts;
   int        total;
   integer    seed;
   integer    randVal;

   controlUnit uut (
      .CLK    (CLK),
      .Reset  (Reset),
      .Opcode (Opcode),
      .State  (State),
      .Ctrl   (Ctrl)
   );

   cuChecker chk (
      .CLK      (CLK),
      .Reset    (Reset),
      .Opcode   (Opcode),
      .State    (State),
      .Ctrl     (Ctrl),
      .ErrCount (checkErrors)
   );

   initial
   begin
      forever #10 CLK = ~CLK;
   end

   function automatic int instrCycles(opcode_t op);
      int n;
      case (op)
         opAdd, opSub, opAnd, opOr, opSlt, opAddi, opOri, opJal: n = 4;
         opLw, opSw:                                         n = 5;
         opLui, opBeq, opBne, opJ, opJr:                     n = 3;
         default:                                            n = 2;   // Illegal
      endcase
      return n;
   endfunction

   task automatic waitForFetch();
      int n;
      n = 0;
      @(negedge CLK);
      while (State != Fetch && n < 10)
      begin
         @(negedge CLK);
         n++;
      end
      if (State != Fetch)
      begin
         timeouts++;
         $display("Timeout: State did not reach Fetch after reset within 10 cycles");
      end
   endtask

   // Starts at a falling edge in Fetch, ends at the next one in Fetch
   task automatic runInstr(opcode_t op);
      int cycles;
      int n;
      bit done;
      cycles = 1;
      n = 0;
      done = 1'b0;
      @(posedge CLK);
      Opcode <= op;
      while (!done && n < 10)
      begin
         @(negedge CLK);
         n++;
         if (State == Fetch)
            done = 1'b1;
         else
            cycles++;
      end
      if (!done)
      begin
         timeouts++;
         $display("Timeout: opcode %0d did not return to Fetch within 10 cycles", op);
      end
      else if (cycles != instrCycles(op))
      begin
         lengthErrors++;
         $display("Fail time=%0t length of opcode %0d expected %0d got %0d", $time, op,
                  instrCycles(op), cycles);
      end
   endtask

   initial
   begin
      seed = 44;
      Reset = 1'b1;
      Opcode = opAdd;
      lengthErrors = 0;
      timeouts = 0;
      repeat (5) @(posedge CLK);
      Reset <= 1'b0;
      waitForFetch();
      for (int i = 0; i < 16; i++)
         runInstr(opcode_t'(i[3:0]));    // Every opcode once, 5 included
      repeat (200)
      begin
         randVal = $random(seed);
         runInstr(opcode_t'(randVal[3:0]));
      end
      @(posedge CLK);    // Last compare done
      total = checkErrors + lengthErrors + timeouts;
      $display("Errors: compare %0d, length %0d, timeout %0d", checkErrors, lengthErrors,
               timeouts);
      if (total == 0)
         $display("All tests passed!");
      else
         $display("Test failures found");
      $finish;
   end

endmodule
